//--- ib_ctrl_pkg.sv
// ====================
// ib stage control package
// shared widths, enums and packed payload types for the fetch ib stage
// ====================

package ib_ctrl_pkg;

    // half-word hint slots per fetch block
    localparam int HN_WIDTH      = 8;
    // low target bits kept in an indirect btb entry
    localparam int IND_TGT_WIDTH = 20;

    // way prediction sent with a pc load
    typedef enum logic [1:0] {
        WAY_NONE = 2'b00,
        WAY_ALL  = 2'b11
    } way_pred_e;

    // indirect btb read wait
    typedef enum logic {
        IND_IDLE = 1'b0,
        IND_WAIT = 1'b1
    } ind_rd_state_e;

    // ==================== incoming payload
    typedef struct packed {
        logic                vld;
        logic                expt_vld;
        logic [HN_WIDTH-1:0] hn_ind_br;
        logic [HN_WIDTH-1:0] hn_pcall;
        logic [HN_WIDTH-1:0] hn_preturn;
    } ib_in_t;

    // indirect btb read data, vld on the msb
    typedef struct packed {
        logic                     vld;
        logic [1:0]               priv;
        logic [IND_TGT_WIDTH-1:0] tgt;
    } ind_btb_entry_t;

    typedef struct packed {
        logic      vld;
        way_pred_e pred;
    } lbuf_chgflw_t;

    // ==================== internal groups
    // hints reduced to one bit each, exception masked
    typedef struct packed {
        logic pcall;
        logic preturn;
        logic ind_br;
    } hint_any_t;

    // buffer covers ibuf full and lbuf special states
    typedef struct packed {
        logic mispred;
        logic buffer;
        logic fifo_full;
        logic fifo;
        logic ind_rd;
    } ib_stall_t;

    typedef struct packed {
        logic lbuf;
        logic ras;
        logic ind;
        logic l0_mispred;
    } chgflw_src_t;

    // ==================== outputs
    typedef struct packed {
        logic      pcload;
        logic      pcload_vld;
        way_pred_e way_pred;
    } pcgen_req_t;

    typedef struct packed {
        logic lbuf_inst_vld;
        logic ibuf_inst_vld;
        logic bypass_inst_vld;
    } idu_issue_t;

    typedef struct packed {
        logic pcall_vld;
        logic preturn_vld;
    } ras_req_t;

endpackage

//--- ib_issue_ctrl.sv
// ====================
// ib stage issue control
// decode issue valids, ibuf retire, pc fifo create and ras requests
// ====================

`timescale 1ns/10ps

module ib_issue_ctrl (
    input  logic                   ib_vld,
    input  ib_ctrl_pkg::hint_any_t hint_any,
    input  ib_ctrl_pkg::ib_stall_t stall,
    input  logic                   ibuf_empty,
    input  logic                   lbuf_active,
    input  logic                   idu_stall,
    input  logic                   pcgen_cancel,
    input  logic                   addrgen_cancel,
    output ib_ctrl_pkg::idu_issue_t idu_issue,
    output logic                   ibuf_retire_vld,
    output logic                   pcfifo_create_vld,
    output ib_ctrl_pkg::ras_req_t  ras_req
);

    import ib_ctrl_pkg::*;

    logic any_stall;

    assign any_stall = |stall;

    // ==================== decode issue
    // exactly one source at a time
    // lbuf active excludes ibuf, ibuf empty excludes bypass
    assign idu_issue.lbuf_inst_vld = lbuf_active && !stall.fifo_full && !stall.mispred;

    assign idu_issue.ibuf_inst_vld = !ibuf_empty && !lbuf_active && !stall.mispred;

    // addrgen cancel kills bypass only, buffered data still goes
    assign idu_issue.bypass_inst_vld = ib_vld && ibuf_empty && !lbuf_active
                                       && !any_stall && !addrgen_cancel;

    // ==================== buffers
    // idu stall holds the head entry
    assign ibuf_retire_vld = !ibuf_empty && !stall.mispred && !idu_stall;

    // fifo full is tracked by iu, not checked here
    assign pcfifo_create_vld = ib_vld && !pcgen_cancel && !addrgen_cancel
                               && !stall.mispred && !stall.ind_rd && !stall.buffer;

    // ==================== ras
    // push and pop only once the block goes through
    assign ras_req.pcall_vld   = hint_any.pcall && ib_vld && !any_stall;
    assign ras_req.preturn_vld = hint_any.preturn && ib_vld && !any_stall;

endmodule

//--- ib_target_sel.sv
// ====================
// ib stage target select
// indirect btb check and priority mux of the change flow pc and way
// ====================

`timescale 1ns/10ps

module ib_target_sel #(
    parameter int PC_WIDTH = 39
) (
    input  ib_ctrl_pkg::chgflw_src_t          chgflw_src,
    input  ib_ctrl_pkg::ind_btb_entry_t       ind_btb_dout,
    input  logic [1:0]                        priv_mode,
    input  logic [PC_WIDTH-1:0]               ib_vpc,
    input  logic [PC_WIDTH-1:0]               default_pc,
    input  logic [PC_WIDTH-1:0]               ras_pc,
    input  ib_ctrl_pkg::lbuf_chgflw_t         lbuf_chgflw,
    input  logic [PC_WIDTH-1:0]               lbuf_chgflw_pc,
    input  logic [PC_WIDTH-1:0]               l0_mispred_pc,
    output logic                              ind_hit,
    output logic [PC_WIDTH-1:0]               pcgen_pc,
    output ib_ctrl_pkg::way_pred_e            way_pred,
    output logic [ib_ctrl_pkg::HN_WIDTH-1:0]  ind_btb_path
);

    import ib_ctrl_pkg::*;

    logic [PC_WIDTH-1:0] ind_pc;
    way_pred_e           ind_way_pred;

    // ==================== indirect target
    // entry valid and written in the current privilege
    assign ind_hit = ind_btb_dout.vld && (ind_btb_dout.priv == priv_mode);

    // upper bits come from the fetch pc itself
    // on a miss fall back to the next sequential block
    assign ind_pc = ind_hit ? {ib_vpc[PC_WIDTH-1:IND_TGT_WIDTH], ind_btb_dout.tgt}
                            : default_pc;

    assign ind_way_pred = ind_hit ? WAY_ALL : WAY_NONE;

    // index into the btb path history
    assign ind_btb_path = ind_pc[10:3];

    // ==================== priority mux
    // lbuf, then ras, then indirect, then l0 mispredict
    always_comb begin
        if (chgflw_src.lbuf) begin
            pcgen_pc = lbuf_chgflw_pc;
            way_pred = lbuf_chgflw.pred;
        end else if (chgflw_src.ras) begin
            pcgen_pc = ras_pc;
            way_pred = WAY_ALL;
        end else if (chgflw_src.ind) begin
            pcgen_pc = ind_pc;
            way_pred = ind_way_pred;
        end else begin
            // l0 mispredict or nothing at all
            pcgen_pc = l0_mispred_pc;
            way_pred = WAY_ALL;
        end
    end

endmodule

//--- ib_stall_ctrl.sv
// ====================
// ib stage stall control
// hint masking, stall terms, change flow valid and the indirect read wait
// ====================

`timescale 1ns/10ps

module ib_stall_ctrl (
    input  logic                     ind_btb_rd_state_clk,
    input  logic                     cpurst_b,
    input  ib_ctrl_pkg::ib_in_t      ip_ib,
    input  logic                     ind_hit,
    input  logic                     l0_mispred_vld,
    input  logic                     ras_chgflw_mask,
    input  logic                     lbuf_chgflw_vld,
    input  logic                     lbuf_active,
    input  logic                     lbuf_stall,
    input  logic                     ibuf_stall,
    input  logic                     pcfifo_full,
    input  logic                     pcfifo_more_than_two,
    input  logic                     iu_mispred_stall,
    input  logic                     pcgen_cancel,
    input  logic                     addrgen_cancel,
    output ib_ctrl_pkg::hint_any_t   hint_any,
    output ib_ctrl_pkg::ib_stall_t   stall,
    output ib_ctrl_pkg::chgflw_src_t chgflw_src,
    // {pcload, pcload_vld}
    output logic [1:0]               way_pred_vld_pcload,
    output logic                     ipctrl_stall,
    output logic                     ind_btb_check_vld
);

    import ib_ctrl_pkg::*;

    ind_rd_state_e ind_rd_state;
    ind_rd_state_e ind_rd_state_nxt;
    logic          ib_vld;
    logic          ib_expt;
    logic          chgflw_vld;
    logic          self_stall;

    assign ib_vld  = ip_ib.vld;
    assign ib_expt = ip_ib.expt_vld;

    // ==================== hints
    // exception payload may carry garbage hints
    assign hint_any.pcall   = (|ip_ib.hn_pcall) && !ib_expt;
    assign hint_any.preturn = (|ip_ib.hn_preturn) && !ib_expt;
    assign hint_any.ind_br  = (|ip_ib.hn_ind_br) && !ib_expt;

    // ==================== stall terms
    // ibuf full with data, or lbuf in a special state
    assign stall.buffer = (ib_vld && ibuf_stall) || lbuf_stall;

    // active lbuf feeds the pc fifo as well
    assign stall.fifo_full = pcfifo_full && (ib_vld || lbuf_active);

    // ras or indirect state must not move while iu recovers
    assign stall.mispred = iu_mispred_stall && ib_vld && !ib_expt
                           && (hint_any.pcall || hint_any.preturn || hint_any.ind_br);

    // too many pc-oper instructions in flight
    assign stall.fifo = ib_vld && pcfifo_more_than_two && !ib_expt;

    // btb result lands one cycle after the read
    assign stall.ind_rd = (ind_rd_state == IND_IDLE) && ib_vld && hint_any.ind_br;

    // fifo and ind_rd stalls are left out here
    // the next cycle repeats the change flow anyway
    assign self_stall = stall.buffer || stall.fifo_full || stall.mispred;

    assign ipctrl_stall = stall.mispred || stall.buffer || stall.fifo_full
                          || stall.fifo || stall.ind_rd;

    // ==================== change flow sources
    assign chgflw_src.lbuf       = lbuf_chgflw_vld;
    assign chgflw_src.ras        = ib_vld && hint_any.preturn;
    // indirect only once the btb data is back
    assign chgflw_src.ind        = ib_vld && hint_any.ind_br && (ind_rd_state == IND_WAIT);
    assign chgflw_src.l0_mispred = l0_mispred_vld;

    // masked return falls through to sequential fetch
    assign chgflw_vld = ((chgflw_src.ras && !ras_chgflw_mask)
                         || chgflw_src.ind
                         || chgflw_src.lbuf
                         || chgflw_src.l0_mispred)
                        && !ib_expt;

    // pcload stays up under back-pressure, vld drops
    assign way_pred_vld_pcload[1] = chgflw_vld;
    assign way_pred_vld_pcload[0] = chgflw_vld && !self_stall;

    // only a hit entry carries a target worth checking
    assign ind_btb_check_vld = chgflw_src.ind && ind_hit && !self_stall && !stall.fifo;

    // ==================== indirect read wait
    always_comb begin
        ind_rd_state_nxt = ind_rd_state;
        if (pcgen_cancel || addrgen_cancel) begin
            ind_rd_state_nxt = IND_IDLE;
        end else if (stall.ind_rd) begin
            ind_rd_state_nxt = IND_WAIT;
        end else if ((ind_rd_state == IND_WAIT) && chgflw_vld
                     && !stall.fifo && !stall.fifo_full) begin
            // jump taken, back to idle
            ind_rd_state_nxt = IND_IDLE;
        end
    end

    always_ff @(posedge ind_btb_rd_state_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            ind_rd_state <= IND_IDLE;
        end else begin
            ind_rd_state <= ind_rd_state_nxt;
        end
    end

endmodule

//--- ib_ctrl_top.sv
// ====================
// ib stage control top
// joins stall control, target select and issue control of the fetch ib stage
// ====================

`timescale 1ns/10ps

module ib_ctrl_top #(
    parameter int PC_WIDTH = 39
) (
    input  logic                                  ind_btb_rd_state_clk,
    input  logic                                  cpurst_b,
    // ib stage payload and pcs
    input  ib_ctrl_pkg::ib_in_t                   ip_ib,
    input  logic [PC_WIDTH-1:0]                   ib_vpc,
    input  logic [PC_WIDTH-1:0]                   default_pc,
    input  logic [PC_WIDTH-1:0]                   l0_mispred_pc,
    input  logic [PC_WIDTH-1:0]                   ras_pc,
    input  logic [PC_WIDTH-1:0]                   lbuf_chgflw_pc,
    input  logic                                  l0_mispred_vld,
    input  logic                                  ras_chgflw_mask,
    // indirect btb
    input  ib_ctrl_pkg::ind_btb_entry_t           ind_btb_dout,
    input  logic [1:0]                            priv_mode,
    // loop buffer and instruction buffer
    input  ib_ctrl_pkg::lbuf_chgflw_t             lbuf_chgflw,
    input  logic                                  lbuf_active,
    input  logic                                  lbuf_stall,
    input  logic                                  ibuf_stall,
    input  logic                                  ibuf_empty,
    // pc fifo and downstream
    input  logic                                  pcfifo_full,
    input  logic                                  pcfifo_more_than_two,
    input  logic                                  iu_mispred_stall,
    input  logic                                  idu_stall,
    input  logic                                  pcgen_cancel,
    input  logic                                  addrgen_cancel,
    // to pc generator
    output logic [PC_WIDTH-1:0]                   pcgen_pc,
    output ib_ctrl_pkg::pcgen_req_t               pcgen,
    output logic                                  ipctrl_stall,
    // to indirect btb
    output logic                                  ind_btb_check_vld,
    output logic [ib_ctrl_pkg::HN_WIDTH-1:0]      ind_btb_path,
    // to decode, buffers, pc fifo and ras
    output ib_ctrl_pkg::idu_issue_t               idu_issue,
    output logic                                  ibuf_retire_vld,
    output logic                                  pcfifo_create_vld,
    output ib_ctrl_pkg::ras_req_t                 ras_req
);

    import ib_ctrl_pkg::*;

    hint_any_t   hint_any;
    ib_stall_t   stall;
    chgflw_src_t chgflw_src;
    logic        ind_hit;
    logic [1:0]  pcload_bits;
    way_pred_e   sel_way_pred;

    // pcload, pcload_vld on top of the selected way
    assign pcgen = {pcload_bits, sel_way_pred};

    // ==================== stall and state machine
    ib_stall_ctrl u_stall_ctrl (
        .ind_btb_rd_state_clk (ind_btb_rd_state_clk),
        .cpurst_b             (cpurst_b),
        .ip_ib                (ip_ib),
        .ind_hit              (ind_hit),
        .l0_mispred_vld       (l0_mispred_vld),
        .ras_chgflw_mask      (ras_chgflw_mask),
        .lbuf_chgflw_vld      (lbuf_chgflw.vld),
        .lbuf_active          (lbuf_active),
        .lbuf_stall           (lbuf_stall),
        .ibuf_stall           (ibuf_stall),
        .pcfifo_full          (pcfifo_full),
        .pcfifo_more_than_two (pcfifo_more_than_two),
        .iu_mispred_stall     (iu_mispred_stall),
        .pcgen_cancel         (pcgen_cancel),
        .addrgen_cancel       (addrgen_cancel),
        .hint_any             (hint_any),
        .stall                (stall),
        .chgflw_src           (chgflw_src),
        .way_pred_vld_pcload  (pcload_bits),
        .ipctrl_stall         (ipctrl_stall),
        .ind_btb_check_vld    (ind_btb_check_vld)
    );

    // ==================== target mux
    ib_target_sel #(
        .PC_WIDTH (PC_WIDTH)
    ) u_target_sel (
        .chgflw_src     (chgflw_src),
        .ind_btb_dout   (ind_btb_dout),
        .priv_mode      (priv_mode),
        .ib_vpc         (ib_vpc),
        .default_pc     (default_pc),
        .ras_pc         (ras_pc),
        .lbuf_chgflw    (lbuf_chgflw),
        .lbuf_chgflw_pc (lbuf_chgflw_pc),
        .l0_mispred_pc  (l0_mispred_pc),
        .ind_hit        (ind_hit),
        .pcgen_pc       (pcgen_pc),
        .way_pred       (sel_way_pred),
        .ind_btb_path   (ind_btb_path)
    );

    // ==================== issue valids
    ib_issue_ctrl u_issue_ctrl (
        .ib_vld            (ip_ib.vld),
        .hint_any          (hint_any),
        .stall             (stall),
        .ibuf_empty        (ibuf_empty),
        .lbuf_active       (lbuf_active),
        .idu_stall         (idu_stall),
        .pcgen_cancel      (pcgen_cancel),
        .addrgen_cancel    (addrgen_cancel),
        .idu_issue         (idu_issue),
        .ibuf_retire_vld   (ibuf_retire_vld),
        .pcfifo_create_vld (pcfifo_create_vld),
        .ras_req           (ras_req)
    );

endmodule

//--- ib_ctrl_sva.sv
// ====================
// ib stage control checker
// reference rules of the ib stage as concurrent assertions, bound into the top
// ====================

`timescale 1ns/10ps

module ib_ctrl_sva #(
    parameter int PC_WIDTH = 39
) (
    input logic                               ind_btb_rd_state_clk,
    input logic                               cpurst_b,
    input ib_ctrl_pkg::ib_in_t                ip_ib,
    input logic [PC_WIDTH-1:0]                ib_vpc,
    input logic [PC_WIDTH-1:0]                default_pc,
    input logic [PC_WIDTH-1:0]                l0_mispred_pc,
    input logic [PC_WIDTH-1:0]                ras_pc,
    input logic [PC_WIDTH-1:0]                lbuf_chgflw_pc,
    input logic                               l0_mispred_vld,
    input logic                               ras_chgflw_mask,
    input ib_ctrl_pkg::ind_btb_entry_t        ind_btb_dout,
    input logic [1:0]                         priv_mode,
    input ib_ctrl_pkg::lbuf_chgflw_t          lbuf_chgflw,
    input logic                               lbuf_active,
    input logic                               lbuf_stall,
    input logic                               ibuf_stall,
    input logic                               ibuf_empty,
    input logic                               pcfifo_full,
    input logic                               pcfifo_more_than_two,
    input logic                               iu_mispred_stall,
    input logic                               pcgen_cancel,
    input logic                               addrgen_cancel,
    input logic [PC_WIDTH-1:0]                pcgen_pc,
    input ib_ctrl_pkg::pcgen_req_t            pcgen,
    input logic                               ipctrl_stall,
    input logic                               ind_btb_check_vld,
    input logic [ib_ctrl_pkg::HN_WIDTH-1:0]   ind_btb_path,
    input ib_ctrl_pkg::idu_issue_t            idu_issue,
    input logic                               ibuf_retire_vld,
    input logic                               pcfifo_create_vld,
    input ib_ctrl_pkg::ras_req_t              ras_req
);

    import ib_ctrl_pkg::*;

    int unsigned         fail_cnt = 0;
    logic                ref_wait;
    logic                hint_ind;
    logic                hint_ret;
    logic                hint_call;
    logic                exp_buf;
    logic                exp_full;
    logic                exp_fifo;
    logic                exp_mis;
    logic                exp_ind_rd;
    logic                exp_self;
    logic                exp_stall;
    logic                src_ras;
    logic                src_ind;
    logic                exp_chg;
    logic                ref_hit;
    logic                idle_in;
    logic [PC_WIDTH-1:0] ind_pc;
    logic [PC_WIDTH-1:0] exp_pc;
    way_pred_e           exp_way;
    idu_issue_t          exp_issue;
    ras_req_t            exp_ras;

    // ==================== reference rules
    // hints count only without an exception
    assign hint_ind   = (|ip_ib.hn_ind_br) && !ip_ib.expt_vld;
    assign hint_ret   = (|ip_ib.hn_preturn) && !ip_ib.expt_vld;
    assign hint_call  = (|ip_ib.hn_pcall) && !ip_ib.expt_vld;
    assign exp_buf    = (ip_ib.vld && ibuf_stall) || lbuf_stall;
    assign exp_full   = pcfifo_full && (ip_ib.vld || lbuf_active);
    assign exp_fifo   = ip_ib.vld && pcfifo_more_than_two && !ip_ib.expt_vld;
    assign exp_mis    = iu_mispred_stall && ip_ib.vld && (hint_ind || hint_ret || hint_call);
    assign exp_ind_rd = !ref_wait && ip_ib.vld && hint_ind;
    assign exp_self   = exp_buf || exp_full || exp_mis;
    assign exp_stall  = exp_self || exp_fifo || exp_ind_rd;
    assign src_ras    = ip_ib.vld && hint_ret;
    assign src_ind    = ip_ib.vld && hint_ind && ref_wait;
    assign exp_chg    = ((src_ras && !ras_chgflw_mask) || src_ind || lbuf_chgflw.vld
                         || l0_mispred_vld) && !ip_ib.expt_vld;
    assign ref_hit    = ind_btb_dout.vld && (ind_btb_dout.priv == priv_mode);
    assign ind_pc     = ref_hit ? {ib_vpc[PC_WIDTH-1:IND_TGT_WIDTH], ind_btb_dout.tgt}
                                : default_pc;

    // decode issue and ras push/pop
    assign exp_issue.lbuf_inst_vld   = lbuf_active && !exp_mis && !exp_full;
    assign exp_issue.ibuf_inst_vld   = !ibuf_empty && !lbuf_active && !exp_mis;
    assign exp_issue.bypass_inst_vld = ip_ib.vld && ibuf_empty && !lbuf_active
                                       && !exp_stall && !addrgen_cancel;
    assign exp_ras.pcall_vld         = hint_call && ip_ib.vld && !exp_stall;
    assign exp_ras.preturn_vld       = hint_ret && ip_ib.vld && !exp_stall;

    assign idle_in = !ip_ib.vld && !lbuf_active && !lbuf_chgflw.vld && !l0_mispred_vld
                     && ibuf_empty && !lbuf_stall;

    // lbuf, ras, indirect, then l0 mispredict
    always_comb begin
        if (lbuf_chgflw.vld) begin
            exp_pc  = lbuf_chgflw_pc;
            exp_way = lbuf_chgflw.pred;
        end else if (src_ras) begin
            exp_pc  = ras_pc;
            exp_way = WAY_ALL;
        end else if (src_ind) begin
            exp_pc  = ind_pc;
            exp_way = ref_hit ? WAY_ALL : WAY_NONE;
        end else begin
            exp_pc  = l0_mispred_pc;
            exp_way = WAY_ALL;
        end
    end

    // shadow of the indirect read wait
    always_ff @(posedge ind_btb_rd_state_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            ref_wait <= 1'b0;
        end else if (pcgen_cancel || addrgen_cancel) begin
            ref_wait <= 1'b0;
        end else if (exp_ind_rd) begin
            ref_wait <= 1'b1;
        end else if (exp_chg && !exp_fifo && !exp_full) begin
            ref_wait <= 1'b0;
        end
    end

    // ==================== assertions
    a_stall: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        ipctrl_stall == exp_stall)
    else begin
        fail_cnt++;
        $error("FAIL %0t: ipctrl_stall differs from the stall terms", $time);
    end

    // one stall cycle, then the jump goes out
    // a hit entry is checked as the jump leaves
    a_ind_once: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        exp_ind_rd && !pcgen_cancel && !addrgen_cancel
        ##1 ip_ib.vld && hint_ind && !exp_self && !exp_fifo
        |-> !ipctrl_stall && pcgen.pcload && ind_btb_check_vld == ref_hit)
    else begin
        fail_cnt++;
        $error("FAIL %0t: indirect branch not released after one wait cycle", $time);
    end

    a_target: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        pcgen_pc == exp_pc && pcgen.way_pred == exp_way
        && (!src_ind || ind_btb_path == ind_pc[10:3]))
    else begin
        fail_cnt++;
        $error("FAIL %0t: target pc %h, expected %h", $time, pcgen_pc, exp_pc);
    end

    // back-pressure keeps pcload but drops its valid
    a_pcload: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        pcgen.pcload == exp_chg && pcgen.pcload_vld == (exp_chg && !exp_self))
    else begin
        fail_cnt++;
        $error("FAIL %0t: pcload %b/%b wrong", $time, pcgen.pcload, pcgen.pcload_vld);
    end

    a_expt: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        ip_ib.expt_vld |-> !pcgen.pcload && ras_req == '0 && !ind_btb_check_vld
        && ipctrl_stall == (exp_buf || exp_full))
    else begin
        fail_cnt++;
        $error("FAIL %0t: exception payload not masked", $time);
    end

    a_check: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        ind_btb_check_vld |-> src_ind && ref_hit)
    else begin
        fail_cnt++;
        $error("FAIL %0t: ind_btb_check_vld without an indirect hit", $time);
    end

    a_issue: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        $onehot0(idu_issue) && idu_issue == exp_issue)
    else begin
        fail_cnt++;
        $error("FAIL %0t: idu_issue %b, expected %b", $time, idu_issue, exp_issue);
    end

    a_ras: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        ras_req == exp_ras && !((|ras_req) && exp_fifo))
    else begin
        fail_cnt++;
        $error("FAIL %0t: ras_req %b, expected %b", $time, ras_req, exp_ras);
    end

    a_idle: assert property (@(posedge ind_btb_rd_state_clk) disable iff (!cpurst_b)
        idle_in |-> !pcgen.pcload && !ipctrl_stall && idu_issue == '0 && ras_req == '0
        && !ibuf_retire_vld && !pcfifo_create_vld && !ind_btb_check_vld)
    else begin
        fail_cnt++;
        $error("FAIL %0t: valid output high with idle inputs", $time);
    end

endmodule

bind ib_ctrl_top ib_ctrl_sva #(
    .PC_WIDTH (PC_WIDTH)
) u_sva (.*);

//--- ib_ctrl_tb_clkgen.sv
// ====================
// testbench clock and reset generator
// ====================

`timescale 1ns/10ps

module ib_ctrl_tb_clkgen #(
    parameter int RST_CYCLES = 2
) (
    output logic ind_btb_rd_state_clk,
    output logic cpurst_b
);

    // 100 ns period
    initial begin
        ind_btb_rd_state_clk = 1'b0;
        forever begin
            #50 ind_btb_rd_state_clk = ~ind_btb_rd_state_clk;
        end
    end

    // reset low for the first cycles, released on an edge
    initial begin
        cpurst_b = 1'b0;
        repeat (RST_CYCLES) @(posedge ind_btb_rd_state_clk);
        cpurst_b <= 1'b1;
    end

endmodule

//--- ib_ctrl_tb.sv
// ====================
// ib stage control testbench
// directed indirect and stall cases, then random traffic
// ====================

`timescale 1ns/10ps

module ib_ctrl_tb;

    import ib_ctrl_pkg::*;

    localparam int PC_WIDTH       = 39;
    localparam int RAND_CYCLES    = 980;
    // twice the stimulus length
    localparam int TIMEOUT_CYCLES = 2000;

    int seed = 18738;
    int cycle_cnt = 0;

    logic                ind_btb_rd_state_clk;
    logic                cpurst_b;
    ib_in_t              ip_ib;
    logic [PC_WIDTH-1:0] ib_vpc;
    logic [PC_WIDTH-1:0] default_pc;
    logic [PC_WIDTH-1:0] l0_mispred_pc;
    logic [PC_WIDTH-1:0] ras_pc;
    logic [PC_WIDTH-1:0] lbuf_chgflw_pc;
    logic                l0_mispred_vld;
    logic                ras_chgflw_mask;
    ind_btb_entry_t      ind_btb_dout;
    logic [1:0]          priv_mode;
    lbuf_chgflw_t        lbuf_chgflw;
    logic                lbuf_active;
    logic                lbuf_stall;
    logic                ibuf_stall;
    logic                ibuf_empty;
    logic                pcfifo_full;
    logic                pcfifo_more_than_two;
    logic                iu_mispred_stall;
    logic                idu_stall;
    logic                pcgen_cancel;
    logic                addrgen_cancel;
    logic [PC_WIDTH-1:0] pcgen_pc;
    pcgen_req_t          pcgen;
    logic                ipctrl_stall;
    logic                ind_btb_check_vld;
    logic [HN_WIDTH-1:0] ind_btb_path;
    idu_issue_t          idu_issue;
    logic                ibuf_retire_vld;
    logic                pcfifo_create_vld;
    ras_req_t            ras_req;

    ib_ctrl_tb_clkgen u_clkgen (.*);

    ib_ctrl_top #(
        .PC_WIDTH (PC_WIDTH)
    ) dut0 (.*);

    function automatic logic [PC_WIDTH-1:0] rand_pc();
        logic [63:0] w;
        w = {$random(seed), $random(seed)};
        return w[PC_WIDTH-1:0];
    endfunction

    task automatic set_idle();
        ip_ib                <= '0;
        ind_btb_dout         <= '0;
        priv_mode            <= 2'b00;
        l0_mispred_vld       <= 1'b0;
        ras_chgflw_mask      <= 1'b0;
        lbuf_chgflw          <= '0;
        lbuf_active          <= 1'b0;
        lbuf_stall           <= 1'b0;
        ibuf_stall           <= 1'b0;
        ibuf_empty           <= 1'b1;
        pcfifo_full          <= 1'b0;
        pcfifo_more_than_two <= 1'b0;
        iu_mispred_stall     <= 1'b0;
        idu_stall            <= 1'b0;
        pcgen_cancel         <= 1'b0;
        addrgen_cancel       <= 1'b0;
    endtask

    // indirect branch held for two cycles, hit or miss
    task automatic run_ind_branch(input logic hit);
        @(posedge ind_btb_rd_state_clk);
        set_idle();
        ip_ib.vld       <= 1'b1;
        ip_ib.hn_ind_br <= 8'h04;
        ind_btb_dout    <= {1'b1, 2'b01, 20'h5a3c7};
        priv_mode       <= hit ? 2'b01 : 2'b11;
        ib_vpc          <= rand_pc();
        default_pc      <= rand_pc();
        repeat (2) @(posedge ind_btb_rd_state_clk);
        set_idle();
    endtask

    // buffer stall, fifo full, then an exception with every hint
    task automatic run_stall_cases();
        @(posedge ind_btb_rd_state_clk);
        set_idle();
        ip_ib.vld       <= 1'b1;
        lbuf_chgflw.vld <= 1'b1;
        ibuf_stall      <= 1'b1;
        @(posedge ind_btb_rd_state_clk);
        ibuf_stall  <= 1'b0;
        pcfifo_full <= 1'b1;
        @(posedge ind_btb_rd_state_clk);
        set_idle();
        ip_ib                <= {1'b1, 1'b1, 8'hff, 8'hff, 8'hff};
        iu_mispred_stall     <= 1'b1;
        pcfifo_more_than_two <= 1'b1;
        @(posedge ind_btb_rd_state_clk);
        set_idle();
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        r = $random(seed);
        s = $random(seed);
        t = $random(seed);
        // payload held half the time so indirect waits can resolve
        if (r[0]) begin
            ip_ib <= {r[1] | r[2], r[5:3] == 3'd0, r[6] ? s[7:0] : 8'h00,
                      r[7] ? s[15:8] : 8'h00, r[8] ? s[23:16] : 8'h00};
        end
        ind_btb_dout         <= {r[9] | r[10], t[21:20], t[19:0]};
        // biased towards a privilege match
        priv_mode            <= r[11] ? t[21:20] : t[23:22];
        ib_vpc               <= rand_pc();
        default_pc           <= rand_pc();
        l0_mispred_pc        <= rand_pc();
        ras_pc               <= rand_pc();
        lbuf_chgflw_pc       <= rand_pc();
        l0_mispred_vld       <= r[12] & r[13];
        ras_chgflw_mask      <= r[14] & r[15];
        lbuf_chgflw          <= {r[16] & r[17], r[18] ? WAY_ALL : WAY_NONE};
        lbuf_active          <= r[19] & r[20];
        lbuf_stall           <= r[21] & r[22] & r[23];
        ibuf_stall           <= r[24] & r[25];
        ibuf_empty           <= r[26];
        pcfifo_full          <= r[27] & r[28];
        pcfifo_more_than_two <= r[29] & r[30] & r[31];
        iu_mispred_stall     <= s[24] & s[25];
        idu_stall            <= s[26];
        pcgen_cancel         <= s[27] & s[28] & s[29];
        addrgen_cancel       <= s[30] & s[31] & s[29];
    endtask

    // ==================== main sequence
    initial begin
        set_idle();
        ib_vpc         <= rand_pc();
        default_pc     <= rand_pc();
        l0_mispred_pc  <= rand_pc();
        ras_pc         <= rand_pc();
        lbuf_chgflw_pc <= rand_pc();
        @(posedge cpurst_b);
        // idle cycles right after reset
        repeat (3) @(posedge ind_btb_rd_state_clk);
        run_ind_branch(1'b1);
        run_ind_branch(1'b0);
        run_stall_cases();
        repeat (RAND_CYCLES) begin
            @(posedge ind_btb_rd_state_clk);
            drive_random();
        end
        @(posedge ind_btb_rd_state_clk);
        set_idle();
        repeat (3) @(posedge ind_btb_rd_state_clk);
        @(negedge ind_btb_rd_state_clk);
        if (dut0.u_sva.fail_cnt == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "%0d assertion failures", dut0.u_sva.fail_cnt);
        end
    end

    // stop at the first assertion failure
    always @(negedge ind_btb_rd_state_clk) begin
        if (dut0.u_sva.fail_cnt != 0) begin
            $display("Checks failed");
            $fatal(1, "an assertion in the checker failed");
        end
    end

    always @(posedge ind_btb_rd_state_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Checks failed");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

endmodule

//--- ib_ctrl_top.f
ib_ctrl_pkg.sv
ib_issue_ctrl.sv
ib_target_sel.sv
ib_stall_ctrl.sv
ib_ctrl_top.sv
ib_ctrl_sva.sv
ib_ctrl_tb_clkgen.sv
ib_ctrl_tb.sv

//--- Bender.yml
package:
  name: ib_ctrl

sources:
  - files:
      - ib_ctrl_pkg.sv
      - ib_issue_ctrl.sv
      - ib_target_sel.sv
      - ib_stall_ctrl.sv
      - ib_ctrl_top.sv
  - target: test
    files:
      - ib_ctrl_sva.sv
      - ib_ctrl_tb_clkgen.sv
      - ib_ctrl_tb.sv
